// ==== gpuPkg.sv ====
`include "gpu_settings.svh"

package gpuPkg;

	// Palette index of one pixel where index 0 means transparent
	typedef logic [3:0] pixelT;
	typedef logic [1:0] depthT;
	typedef logic [4:0] paletteT;

	// Buffer entry holds the palette in the upper bits above the pixel
	typedef logic [8:0] entryT;

	// Four entries per word with the lowest pixel position in bits 8:0
	typedef logic [35:0] wordDataT;
	typedef logic [7:0] wordDepthT;
	typedef logic [3:0] wordFlagsT;

	// Eight pixels per tile row, leftmost pixel in the low nibble
	typedef logic [31:0] tileWordT;

	// Pixels F, G and H of the previous tile with H on top
	typedef logic [11:0] carryT;

	typedef logic [`WORD_ADDR_W-1:0] wordAddrT;
	typedef logic [`TILE_ADDR_W-1:0] tileAddrT;
	typedef logic [`WORD_ADDR_W+1:0] xPosT;
	typedef logic [`MAX_TILES_W-1:0] widthT;

	typedef enum logic [2:0] {
		fetchIdle,
		fetchBus,
		fetchFirst,
		fetchSecond,
		fetchFlush
	} fetchStateT;

endpackage

// ==== gpu_settings.svh ====
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// Sizes of the line buffer and of the tile memory seen by the compositor

// Number of four-pixel words in one scanline buffer
`define LINE_WORDS 16

// Address width of one line-buffer word
`define WORD_ADDR_W 4

// Word address width of tile memory, one 32-bit tile row per address
`define TILE_ADDR_W 10

// Width of the sprite width field counted in tiles
`define MAX_TILES_W 3

`endif

// ==== lineBuffer.sv ====
`timescale 1ns/1ps
`include "gpu_settings.svh"

module lineBuffer (
	input  logic                clk,
	input  logic                arstN,
	input  logic                lineStart,
	input  gpuPkg::wordAddrT    rdAddr,
	input  logic                wrEn,
	input  gpuPkg::wordAddrT    wrAddr,
	input  gpuPkg::wordDataT    wrData,
	input  gpuPkg::wordDepthT   wrDepth,
	input  gpuPkg::wordFlagsT   wrFlags,
	input  gpuPkg::wordAddrT    scanAddr,
	output gpuPkg::wordDataT    rdData,
	output gpuPkg::wordDepthT   rdDepth,
	output gpuPkg::wordFlagsT   rdFlags,
	output gpuPkg::wordDataT    scanData
);
	import gpuPkg::*;

	wordDataT dataMem [`LINE_WORDS];
	wordDepthT depthMem [`LINE_WORDS];
	wordFlagsT flagMem [`LINE_WORDS];

	// Read and write of the same word in one cycle
	logic fwdHit;

	assign fwdHit = wrEn && (wrAddr == rdAddr);

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (wrEn) begin
			dataMem[wrAddr] <= wrData;
			depthMem[wrAddr] <= wrDepth;
		end
	end

	// Start of a line wins over the flags of a write on the same edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `LINE_WORDS; i++) begin
				flagMem[i] <= '0;
			end
		end else if (lineStart) begin
			for (int i = 0; i < `LINE_WORDS; i++) begin
				flagMem[i] <= '0;
			end
		end else if (wrEn) begin
			flagMem[wrAddr] <= wrFlags;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Merge read port returns what the word holds after this edge
	always_ff @(posedge clk) begin
		if (fwdHit) begin
			rdData <= wrData;
			rdDepth <= wrDepth;
		end else begin
			rdData <= dataMem[rdAddr];
			rdDepth <= depthMem[rdAddr];
		end
		if (lineStart)
			rdFlags <= '0;
		else if (fwdHit)
			rdFlags <= wrFlags;
		else
			rdFlags <= flagMem[rdAddr];
	end

	// Scan-out sees finished words only
	always_ff @(posedge clk) begin
		scanData <= dataMem[scanAddr];
	end

	// Within a line a write only ever adds updated flags to a word
	wrFlagsGrow: assert property (@(posedge clk) disable iff (!arstN)
		wrEn |-> ((wrFlags & flagMem[wrAddr]) == flagMem[wrAddr]));

endmodule

// ==== pixelMerge.sv ====
`timescale 1ns/1ps

module pixelMerge (
	input  logic                clk,
	input  logic                arstN,
	input  logic                reqValid,
	input  gpuPkg::wordAddrT    reqAddr,
	input  logic                reqFirst,
	input  logic [1:0]          reqOffset,
	input  logic                reqFlush,
	input  gpuPkg::tileWordT    reqTile,
	input  gpuPkg::depthT       reqDepth,
	input  gpuPkg::paletteT     reqPalette,
	input  gpuPkg::wordDataT    rdData,
	input  gpuPkg::wordDepthT   rdDepth,
	input  gpuPkg::wordFlagsT   rdFlags,
	output logic                wrEn,
	output gpuPkg::wordAddrT    wrAddr,
	output gpuPkg::wordDataT    wrData,
	output gpuPkg::wordDepthT   wrDepth,
	output gpuPkg::wordFlagsT   wrFlags
);
	import gpuPkg::*;

	logic s2Valid;
	logic s2Flush;
	logic s2First;
	wordAddrT s2Addr;
	logic [1:0] s2Offset;
	tileWordT s2Tile;
	depthT s2Depth;
	paletteT s2Palette;
	carryT carry;

	// Carried pixels followed by the eight tile pixels
	pixelT seq [11];
	pixelT pix [4];
	logic [3:0] base;
	logic [3:0] takeNew;

	////////////////////
	// Request stage
	////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			s2Valid <= 1'b0;
			s2Flush <= 1'b0;
		end else begin
			s2Valid <= reqValid;
			s2Flush <= reqFlush;
		end
	end

	// A flush merges a blank tile as a first half so only the carry shows
	always_ff @(posedge clk) begin
		s2Addr <= reqAddr;
		s2First <= reqFirst || reqFlush;
		s2Offset <= reqOffset;
		s2Tile <= reqFlush ? '0 : reqTile;
		s2Depth <= reqDepth;
		s2Palette <= reqPalette;
	end

	// Every unaligned sprite ends with a flush, so the carry is empty when
	// the first tile of the next sprite arrives
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			carry <= '0;
		end else if (s2Flush) begin
			carry <= '0;
		end else if (s2Valid && !s2First && s2Offset != 2'd0) begin
			carry <= s2Tile[31:20];
		end
	end

	////////////////////
	// Pixel alignment
	////////////////////

	// Word pixel j takes sequence entry 3 + j - offset in the first half
	// and 7 + j - offset in the second half
	always_comb begin
		seq[0] = carry[3:0];
		seq[1] = carry[7:4];
		seq[2] = carry[11:8];
		for (int i = 0; i < 8; i++) begin
			seq[i + 3] = s2Tile[4*i +: 4];
		end
		base = (s2First ? 4'd3 : 4'd7) - {2'b00, s2Offset};
		for (int j = 0; j < 4; j++) begin
			pix[j] = seq[base + 4'(j)];
		end
	end

	////////////////////
	// Depth priority
	////////////////////

	// Untouched pixels always take the new value, even a transparent one
	// Touched pixels only yield to a visible pixel of strictly greater depth
	always_comb begin
		for (int j = 0; j < 4; j++) begin
			takeNew[j] = !rdFlags[j] || ((pix[j] != '0) && (s2Depth > rdDepth[2*j +: 2]));
			wrData[9*j +: 9] = takeNew[j] ? entryT'({s2Palette, pix[j]}) : rdData[9*j +: 9];
			wrDepth[2*j +: 2] = takeNew[j] ? s2Depth : rdDepth[2*j +: 2];
		end
		wrFlags = rdFlags | takeNew;
	end

	assign wrEn = s2Valid;
	assign wrAddr = s2Addr;

	// Back-to-back writes step through the line one word at a time
	wrAddrStep: assert property (@(posedge clk) disable iff (!arstN)
		(wrEn && $past(wrEn)) |-> (wrAddr == $past(wrAddr) + 1'b1));

endmodule

// ==== sim.f ====
+incdir+.
gpuPkg.sv
lineBuffer.sv
pixelMerge.sv
spriteFetch.sv
spriteLineComposer.sv
tbTileModel.sv
tbSpriteLineComposer.sv

// ==== spriteFetch.sv ====
`timescale 1ns/1ps
`include "gpu_settings.svh"

module spriteFetch (
	input  logic               clk,
	input  logic               arstN,
	input  logic               cmdValid,
	input  gpuPkg::xPosT       cmdX,
	input  gpuPkg::depthT      cmdDepth,
	input  gpuPkg::paletteT    cmdPalette,
	input  gpuPkg::tileAddrT   cmdTileAddr,
	input  gpuPkg::widthT      cmdWidth,
	input  gpuPkg::tileWordT   wbDatI,
	input  logic               wbAck,
	output logic               cmdReady,
	output logic               busy,
	output logic               wbCyc,
	output logic               wbStb,
	output gpuPkg::tileAddrT   wbAdr,
	output logic               reqValid,
	output gpuPkg::wordAddrT   reqAddr,
	output logic               reqFirst,
	output logic [1:0]         reqOffset,
	output logic               reqFlush,
	output gpuPkg::tileWordT   reqTile,
	output gpuPkg::depthT      reqDepth,
	output gpuPkg::paletteT    reqPalette
);
	import gpuPkg::*;

	// Word pointer is wide enough to run past the buffer end without wrapping
	localparam int PTR_W = `WORD_ADDR_W + `MAX_TILES_W;

	fetchStateT state;
	widthT tilesLeft;
	logic [1:0] drainCnt;
	logic [PTR_W-1:0] wordPtr;
	logic [1:0] offsetReg;
	depthT depthReg;
	paletteT paletteReg;
	tileWordT tileReg;
	logic cmdFire;

	assign cmdReady = !busy;
	assign cmdFire = cmdValid && cmdReady;

	////////////////////
	// Control FSM
	////////////////////

	// The drain count keeps busy up until the merge stage has written the last word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= fetchIdle;
			busy <= 1'b0;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			tilesLeft <= '0;
			drainCnt <= '0;
		end else begin
			case (state)
				fetchIdle: begin
					if (cmdFire) begin
						busy <= 1'b1;
						tilesLeft <= cmdWidth;
						if (cmdWidth != '0) begin
							state <= fetchBus;
							wbCyc <= 1'b1;
							wbStb <= 1'b1;
						end else begin
							drainCnt <= 2'd2;
						end
					end else if (drainCnt != '0) begin
						drainCnt <= drainCnt - 1'b1;
						if (drainCnt == 2'd1)
							busy <= 1'b0;
					end
				end
				fetchBus: begin
					// Cycle and strobe drop on the edge that samples the ack
					if (wbAck) begin
						wbCyc <= 1'b0;
						wbStb <= 1'b0;
						tilesLeft <= tilesLeft - 1'b1;
						state <= fetchFirst;
					end
				end
				fetchFirst: begin
					state <= fetchSecond;
				end
				fetchSecond: begin
					if (tilesLeft != '0) begin
						state <= fetchBus;
						wbCyc <= 1'b1;
						wbStb <= 1'b1;
					end else if (offsetReg != 2'd0) begin
						state <= fetchFlush;
					end else begin
						state <= fetchIdle;
						drainCnt <= 2'd2;
					end
				end
				fetchFlush: begin
					state <= fetchIdle;
					drainCnt <= 2'd2;
				end
				default: state <= fetchIdle;
			endcase
		end
	end

	////////////////////
	// Command and tile registers
	////////////////////

	always_ff @(posedge clk) begin
		if (cmdFire) begin
			wbAdr <= cmdTileAddr;
			wordPtr <= PTR_W'(cmdX[`WORD_ADDR_W+1:2]);
			offsetReg <= cmdX[1:0];
			depthReg <= cmdDepth;
			paletteReg <= cmdPalette;
		end
		if (state == fetchBus && wbAck) begin
			tileReg <= wbDatI;
			wbAdr <= wbAdr + 1'b1;
		end
		// Each tile covers two consecutive buffer words
		if (state == fetchFirst || state == fetchSecond)
			wordPtr <= wordPtr + 1'b1;
	end

	// Words past the end of the line are dropped, which clips the sprite
	assign reqValid = (state == fetchFirst || state == fetchSecond || state == fetchFlush) &&
		(wordPtr < `LINE_WORDS);
	assign reqAddr = wordPtr[`WORD_ADDR_W-1:0];
	assign reqFirst = (state == fetchFirst);
	// Flush marker is given even when the word itself is clipped
	assign reqFlush = (state == fetchFlush);
	assign reqOffset = offsetReg;
	assign reqTile = tileReg;
	assign reqDepth = depthReg;
	assign reqPalette = paletteReg;

	// Strobe and address hold steady until the slave acks
	wbHoldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
		(wbCyc && wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)));

endmodule

// ==== spriteLineComposer.sv ====
`timescale 1ns/1ps

module spriteLineComposer (
	input  logic                clk,
	input  logic                arstN,
	input  logic                cmdValid,
	input  gpuPkg::xPosT        cmdX,
	input  gpuPkg::depthT       cmdDepth,
	input  gpuPkg::paletteT     cmdPalette,
	input  gpuPkg::tileAddrT    cmdTileAddr,
	input  gpuPkg::widthT       cmdWidth,
	output logic                cmdReady,
	output logic                wbCyc,
	output logic                wbStb,
	output gpuPkg::tileAddrT    wbAdr,
	input  gpuPkg::tileWordT    wbDatI,
	input  logic                wbAck,
	input  logic                lineStart,
	input  gpuPkg::wordAddrT    scanAddr,
	output gpuPkg::wordDataT    scanData,
	output logic                busy
);
	import gpuPkg::*;

	// Word requests from the fetch side
	logic reqValid;
	wordAddrT reqAddr;
	logic reqFirst;
	logic [1:0] reqOffset;
	logic reqFlush;
	tileWordT reqTile;
	depthT reqDepth;
	paletteT reqPalette;

	// Buffer read result and merged write
	wordDataT rdData;
	wordDepthT rdDepth;
	wordFlagsT rdFlags;
	logic wrEn;
	wordAddrT wrAddr;
	wordDataT wrData;
	wordDepthT wrDepth;
	wordFlagsT wrFlags;

	spriteFetch fetch (
		.clk(clk), .arstN(arstN),
		.cmdValid(cmdValid), .cmdX(cmdX), .cmdDepth(cmdDepth),
		.cmdPalette(cmdPalette), .cmdTileAddr(cmdTileAddr), .cmdWidth(cmdWidth),
		.wbDatI(wbDatI), .wbAck(wbAck),
		.cmdReady(cmdReady), .busy(busy),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
		.reqValid(reqValid), .reqAddr(reqAddr), .reqFirst(reqFirst),
		.reqOffset(reqOffset), .reqFlush(reqFlush), .reqTile(reqTile),
		.reqDepth(reqDepth), .reqPalette(reqPalette)
	);

	pixelMerge merge (
		.clk(clk), .arstN(arstN),
		.reqValid(reqValid), .reqAddr(reqAddr), .reqFirst(reqFirst),
		.reqOffset(reqOffset), .reqFlush(reqFlush), .reqTile(reqTile),
		.reqDepth(reqDepth), .reqPalette(reqPalette),
		.rdData(rdData), .rdDepth(rdDepth), .rdFlags(rdFlags),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.wrDepth(wrDepth), .wrFlags(wrFlags)
	);

	// The buffer read is addressed straight by the request
	lineBuffer buffer (
		.clk(clk), .arstN(arstN), .lineStart(lineStart),
		.rdAddr(reqAddr),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.wrDepth(wrDepth), .wrFlags(wrFlags),
		.scanAddr(scanAddr),
		.rdData(rdData), .rdDepth(rdDepth), .rdFlags(rdFlags),
		.scanData(scanData)
	);

endmodule

// ==== tbSpriteLineComposer.sv ====
`timescale 1ns/1ps
`include "gpu_settings.svh"

module tbSpriteLineComposer;
	import gpuPkg::*;

	localparam int MAX_CMDS = 16;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic arstN;
	logic cmdValid;
	xPosT cmdX;
	depthT cmdDepth;
	paletteT cmdPalette;
	tileAddrT cmdTileAddr;
	widthT cmdWidth;
	logic cmdReady;
	logic wbCyc;
	logic wbStb;
	tileAddrT wbAdr;
	tileWordT wbDatI;
	logic wbAck;
	logic lineStart;
	wordAddrT scanAddr;
	wordDataT scanData;
	logic busy;

	// Command table, a set newLine bit opens a fresh scanline
	int numCmds;
	logic tabNewLine [MAX_CMDS];
	xPosT tabX [MAX_CMDS];
	depthT tabDepth [MAX_CMDS];
	paletteT tabPalette [MAX_CMDS];
	tileAddrT tabTile [MAX_CMDS];
	widthT tabWidth [MAX_CMDS];
	string tabCategory [MAX_CMDS];

	// Expected line buffer, words never written are not compared
	wordDataT refData [`LINE_WORDS];
	wordDepthT refDepth [`LINE_WORDS];
	wordFlagsT refFlags [`LINE_WORDS];
	logic refKnown [`LINE_WORDS];

	int passCount;
	int failCount;
	int errCount;
	logic timedOut;
	int idx;
	int testNum;
	string category;

	spriteLineComposer UUT (
		.clk(clk), .arstN(arstN),
		.cmdValid(cmdValid), .cmdX(cmdX), .cmdDepth(cmdDepth),
		.cmdPalette(cmdPalette), .cmdTileAddr(cmdTileAddr), .cmdWidth(cmdWidth),
		.cmdReady(cmdReady),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbDatI(wbDatI), .wbAck(wbAck),
		.lineStart(lineStart), .scanAddr(scanAddr), .scanData(scanData), .busy(busy)
	);

	tbTileModel tileMem (
		.clk(clk), .arstN(arstN), .cyc(wbCyc), .stb(wbStb),
		.adr(wbAdr), .dat(wbDatI), .ack(wbAck)
	);

	always #2 clk = ~clk;

	// Same address scramble as the tile memory model
	function automatic tileWordT tileWordAt(input tileAddrT a);
		tileWordT h;
		tileWordT w;
		h = {a[4:0], a ^ 10'h2d3, a[9:3] ^ 7'h55, a[3:0] ^ a[9:6], a[5:0] ^ 6'h2a};
		for (int i = 0; i < 8; i++) begin
			if (h[4*i+2 +: 2] == 2'b00)
				w[4*i +: 4] = 4'h0;
			else
				w[4*i +: 4] = h[4*i +: 4];
		end
		return w;
	endfunction

	task automatic addRow(input logic newLine, input int x, input int depth, input int pal,
		input int tile, input int width, input string cat);
		tabNewLine[numCmds] = newLine;
		tabX[numCmds] = xPosT'(x);
		tabDepth[numCmds] = depthT'(depth);
		tabPalette[numCmds] = paletteT'(pal);
		tabTile[numCmds] = tileAddrT'(tile);
		tabWidth[numCmds] = widthT'(width);
		tabCategory[numCmds] = cat;
		numCmds++;
	endtask

	task automatic fillTable();
		// Whole line written aligned, pixel value 0 included
		addRow(1'b1, 0, 1, 'h03, 'h010, 7, "aligned");
		addRow(1'b0, 56, 1, 'h04, 'h020, 1, "aligned");
		// Offsets 1 to 3 with carry and flush words, two of them sharing word 5
		addRow(1'b1, 5, 2, 'h07, 'h040, 2, "unaligned");
		addRow(1'b0, 23, 3, 'h0b, 'h060, 1, "unaligned");
		addRow(1'b0, 38, 0, 'h09, 'h080, 3, "unaligned");
		// Higher, equal and lower depth over the same span
		addRow(1'b1, 8, 1, 'h02, 'h100, 3, "depth overlap");
		addRow(1'b0, 10, 3, 'h11, 'h200, 2, "depth overlap");
		addRow(1'b0, 12, 1, 'h15, 'h300, 2, "depth overlap");
		addRow(1'b0, 4, 0, 'h1f, 'h0f0, 3, "depth overlap");
		// Lowest depth still wins once the flags are cleared
		addRow(1'b1, 9, 0, 'h06, 'h155, 4, "new line overwrite");
		// Sprites running off the right end, word 0 must keep its old value
		addRow(1'b1, 51, 2, 'h0c, 'h3a0, 5, "clipping");
		addRow(1'b0, 60, 3, 'h1a, 'h3c0, 7, "clipping");
		addRow(1'b0, 63, 1, 'h13, 'h2e0, 1, "clipping");
	endtask

	////////////////////
	// Reference line model
	////////////////////

	// Words x/4 up to x/4 + 2*width, the last only for unaligned x
	// Every pixel of a written word is merged, outside the sprite with value 0
	task automatic applyRef(input int row);
		int x;
		int w;
		int nWords;
		int wa;
		int s;
		pixelT pix;
		tileWordT tw;
		logic take;
		x = int'(tabX[row]);
		w = int'(tabWidth[row]);
		nWords = (w == 0) ? 0 : 2 * w + ((x % 4 != 0) ? 1 : 0);
		for (int k = 0; k < nWords; k++) begin
			wa = x / 4 + k;
			if (wa < `LINE_WORDS) begin
				for (int j = 0; j < 4; j++) begin
					s = 4 * wa + j - x;
					pix = '0;
					if (s >= 0 && s < 8 * w) begin
						tw = tileWordAt(tabTile[row] + tileAddrT'(s / 8));
						pix = tw[4 * (s % 8) +: 4];
					end
					take = !refFlags[wa][j] ||
						(pix != '0 && tabDepth[row] > refDepth[wa][2*j +: 2]);
					if (take) begin
						refData[wa][9*j +: 9] = {tabPalette[row], pix};
						refDepth[wa][2*j +: 2] = tabDepth[row];
					end
					refFlags[wa][j] = 1'b1;
				end
				refKnown[wa] = 1'b1;
			end
		end
	endtask

	////////////////////
	// Driving and checking
	////////////////////

	// Called right after a rising edge, returns right after a rising edge
	task automatic sendCmd(input int row);
		int waitCnt;
		logic accepted;
		logic idle;
		cmdValid <= 1'b1;
		cmdX <= tabX[row];
		cmdDepth <= tabDepth[row];
		cmdPalette <= tabPalette[row];
		cmdTileAddr <= tabTile[row];
		cmdWidth <= tabWidth[row];
		accepted = 1'b0;
		waitCnt = 0;
		while (!accepted && waitCnt < WAIT_LIMIT) begin
			@(posedge clk);
			accepted = cmdReady;
			waitCnt++;
		end
		cmdValid <= 1'b0;
		if (!accepted) begin
			$display("Command %0d was never accepted, cmdReady stayed low", row);
			timedOut = 1'b1;
		end else begin
			idle = 1'b0;
			waitCnt = 0;
			while (!idle && waitCnt < WAIT_LIMIT) begin
				@(posedge clk);
				idle = !busy;
				waitCnt++;
			end
			if (!idle) begin
				$display("Command %0d never finished, busy stayed high", row);
				timedOut = 1'b1;
			end
		end
	endtask

	// Scan data is registered, so it is sampled a full cycle after the address
	task automatic checkLine();
		for (int w = 0; w < `LINE_WORDS; w++) begin
			@(posedge clk);
			scanAddr <= wordAddrT'(w);
			@(posedge clk);
			@(negedge clk);
			if (refKnown[w] && scanData !== refData[w]) begin
				$display("ERROR scanData word %0d expected %09h actual %09h",
					w, refData[w], scanData);
				errCount++;
			end
		end
	endtask

	task automatic checkIdleAfterReset();
		if (busy !== 1'b0) begin
			$display("ERROR busy expected %h actual %h", 1'b0, busy);
			errCount++;
		end
		if (cmdReady !== 1'b1) begin
			$display("ERROR cmdReady expected %h actual %h", 1'b1, cmdReady);
			errCount++;
		end
		if (wbCyc !== 1'b0) begin
			$display("ERROR wbCyc expected %h actual %h", 1'b0, wbCyc);
			errCount++;
		end
		if (wbStb !== 1'b0) begin
			$display("ERROR wbStb expected %h actual %h", 1'b0, wbStb);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name);
		testNum++;
		if (errCount == 0 && !timedOut) begin
			passCount++;
			$display("Test %0d (%s): PASS", testNum, name);
		end else begin
			failCount++;
			$display("Test %0d (%s): FAIL with %0d mismatches", testNum, name, errCount);
		end
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmdX = '0;
		cmdDepth = '0;
		cmdPalette = '0;
		cmdTileAddr = '0;
		cmdWidth = '0;
		lineStart = 1'b0;
		scanAddr = '0;
		numCmds = 0;
		passCount = 0;
		failCount = 0;
		testNum = 0;
		timedOut = 1'b0;
		for (int w = 0; w < `LINE_WORDS; w++) begin
			refKnown[w] = 1'b0;
			refFlags[w] = '0;
			refData[w] = '0;
			refDepth[w] = '0;
		end
		fillTable();
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		errCount = 0;
		checkIdleAfterReset();
		reportTest("idle after reset");

		// One scanline per pass, checked as a whole once its sprites are done
		idx = 0;
		while (idx < numCmds && !timedOut) begin
			category = tabCategory[idx];
			errCount = 0;
			@(posedge clk);
			lineStart <= 1'b1;
			for (int w = 0; w < `LINE_WORDS; w++) begin
				refFlags[w] = '0;
			end
			@(posedge clk);
			lineStart <= 1'b0;
			do begin
				applyRef(idx);
				sendCmd(idx);
				idx++;
			end while (idx < numCmds && !tabNewLine[idx] && !timedOut);
			if (!timedOut)
				checkLine();
			reportTest(category);
		end

		$display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (failCount == 0 && !timedOut) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tbTileModel.sv ====
`timescale 1ns/1ps

module tbTileModel (
	input  logic                clk,
	input  logic                arstN,
	input  logic                cyc,
	input  logic                stb,
	input  gpuPkg::tileAddrT    adr,
	output gpuPkg::tileWordT    dat,
	output logic                ack
);
	import gpuPkg::*;

	// Extra cycles still to wait before the next ack is given
	logic [1:0] holdCnt;

	// Tile row contents as a scramble of the address bits
	// Pixels whose two upper bits are clear read as transparent
	function automatic tileWordT tileWordAt(input tileAddrT a);
		tileWordT h;
		tileWordT w;
		h = {a[4:0], a ^ 10'h2d3, a[9:3] ^ 7'h55, a[3:0] ^ a[9:6], a[5:0] ^ 6'h2a};
		for (int i = 0; i < 8; i++) begin
			if (h[4*i+2 +: 2] == 2'b00)
				w[4*i +: 4] = 4'h0;
			else
				w[4*i +: 4] = h[4*i +: 4];
		end
		return w;
	endfunction

	////////////////////
	// Wishbone classic slave
	////////////////////

	// Ack lasts one cycle, the master drops the strobe on the edge that sees it
	// Ack delays follow a fixed random seed
	initial begin
		void'($urandom(32'h9fcc_05ab));
		forever begin
			@(posedge clk or negedge arstN);
			if (!arstN) begin
				ack <= 1'b0;
				dat <= '0;
				holdCnt <= '0;
			end else begin
				ack <= 1'b0;
				if (cyc && stb && !ack) begin
					if (holdCnt == 2'd0) begin
						ack <= 1'b1;
						dat <= tileWordAt(adr);
						// Wait for the following strobe is drawn now
						holdCnt <= 2'($urandom_range(3, 0));
					end else begin
						holdCnt <= holdCnt - 1'b1;
					end
				end
			end
		end
	end

endmodule
